// File: Bender.yml
package:
  name: tmr_channel

sources:
  - design/tmr_ctrl_pkg.sv
  - design/tmr_data_pkg.sv
  - design/tmr_event_detect.sv
  - design/tmr_mode_ctrl.sv
  - design/tmr_waveform_gen.sv
  - design/tmr_capture_bank.sv
  - design/tmr_snap_irq.sv
  - design/tmr_channel_top.sv
  - target: test
    files:
      - testbench/tb_tmr_channel.sv

// File: design/tmr_capture_bank.sv
`timescale 1ns/1ps

module tmr_capture_bank import tmr_data_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_enable,
    input  logic               i_cap_run,
    input  logic               i_din_evt,
    input  logic               i_clear,
    input  cnt_t               i_cnt,
    input  logic [CAP_NUM-1:0] i_ovf_over,  // 1 overwrite, 0 discard.
    input  logic [CAP_NUM-1:0] i_read_flag, // clears the matching status bit.
    input  logic               i_snap,
    output tmr_cap_t           o_cap,
    output logic               o_full
);

    tmr_cap_t           cap_q;
    logic [1:0]         idx_q; // rotation pointer 0, 1, 2.
    logic               snap_d_q;
    logic               snap_rise;
    logic               take;
    logic               slot_free;
    logic [CAP_NUM-1:0] slot_mask;

    assign take      = i_cap_run && i_din_evt;
    assign slot_free = !cap_q.status[idx_q] || i_ovf_over[idx_q];
    assign snap_rise = i_snap && !snap_d_q;
    assign o_full    = &cap_q.status;

    always_comb begin
        slot_mask        = '0;
        slot_mask[idx_q] = 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            snap_d_q <= 1'b0;
        end else begin
            snap_d_q <= i_snap;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cap_q <= '0;
            idx_q <= '0;
            o_cap <= '0;
        end else if (!i_enable || i_clear) begin
            cap_q <= '0;
            idx_q <= '0;
            o_cap <= '0;
        end else begin
            // status is set on every edge, even when the value is discarded.
            cap_q.status <= (cap_q.status & ~i_read_flag) | (take ? slot_mask : '0);
            if (take) begin
                if (slot_free) begin
                    cap_q.val[idx_q] <= i_cnt;
                end
                idx_q <= (idx_q == 2'(CAP_NUM - 1)) ? 2'd0 : idx_q + 2'd1;
            end
            if (snap_rise) begin
                o_cap <= cap_q; // copy of the bank as it was before this edge.
            end
        end
    end

endmodule

// File: design/tmr_channel_top.sv
`timescale 1ns/1ps

module tmr_channel_top import tmr_ctrl_pkg::*, tmr_data_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_enable,
    input  tmr_mode_e            i_mode,
    input  logic                 i_ext_a,
    input  logic                 i_ext_b,
    input  logic [INNER_NUM-1:0] i_inner,
    input  tmr_sel_t             i_sel_start,
    input  tmr_sel_t             i_sel_stop,
    input  tmr_sel_t             i_sel_din0,
    input  tmr_sel_t             i_sel_din1,
    input  logic                 i_sw_start,
    input  logic                 i_sw_stop,
    input  logic                 i_sw_clear,
    input  tmr_tgt_ctrl_t        i_tgt_ctrl,
    input  tmr_targets_t         i_tgt_a,
    input  tmr_targets_t         i_tgt_b,
    input  logic [5:0]           i_ovf_over,  // [2:0] bank a, [5:3] bank b.
    input  logic [5:0]           i_read_flag,
    input  logic [1:0]           i_snap,
    output tmr_cap_t             o_cap_a,
    output tmr_cap_t             o_cap_b,
    output cnt_t                 o_shadow,
    output logic [2:0]           o_int,
    output logic                 o_dout_a,
    output logic                 o_dout_b,
    output logic                 o_oen_a,
    output logic                 o_oen_b
);

    tmr_events_t events;
    logic        sw_clear;
    cnt_t        cnt;
    logic        wave_run;
    logic        cap_run;
    logic        restart;
    logic        hit_t2_a;
    logic        hit_t2_b;
    logic        full_a;
    logic        full_b;

    tmr_event_detect u_event_detect (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ext_a    (i_ext_a),
        .i_ext_b    (i_ext_b),
        .i_inner    (i_inner),
        .i_sel_start(i_sel_start),
        .i_sel_stop (i_sel_stop),
        .i_sel_din0 (i_sel_din0),
        .i_sel_din1 (i_sel_din1),
        .i_sw_start (i_sw_start),
        .i_sw_stop  (i_sw_stop),
        .i_sw_clear (i_sw_clear),
        .o_events   (events),
        .o_sw_clear (sw_clear)
    );

    tmr_mode_ctrl u_mode_ctrl (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_enable  (i_enable),
        .i_mode    (i_mode),
        .i_tgt_ctrl(i_tgt_ctrl),
        .i_events  (events),
        .i_sw_clear(sw_clear),
        .i_hit_t2_a(hit_t2_a),
        .i_hit_t2_b(hit_t2_b),
        .o_cnt     (cnt),
        .o_wave_run(wave_run),
        .o_cap_run (cap_run),
        .o_oen_a   (o_oen_a),
        .o_oen_b   (o_oen_b),
        .o_restart (restart)
    );

    tmr_waveform_gen u_waveform_gen (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_enable  (i_enable),
        .i_wave_run(wave_run),
        .i_restart (restart),
        .i_cnt     (cnt),
        .i_tgt_a   (i_tgt_a),
        .i_tgt_b   (i_tgt_b),
        .i_tgt_ctrl(i_tgt_ctrl),
        .o_dout_a  (o_dout_a),
        .o_dout_b  (o_dout_b),
        .o_hit_t2_a(hit_t2_a),
        .o_hit_t2_b(hit_t2_b)
    );

    // din0 feeds bank a.
    tmr_capture_bank u_cap_bank_a (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_cap_run  (cap_run),
        .i_din_evt  (events.din0),
        .i_clear    (sw_clear),
        .i_cnt      (cnt),
        .i_ovf_over (i_ovf_over[2:0]),
        .i_read_flag(i_read_flag[2:0]),
        .i_snap     (i_snap[1]),
        .o_cap      (o_cap_a),
        .o_full     (full_a)
    );

    // din1 feeds bank b.
    tmr_capture_bank u_cap_bank_b (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_cap_run  (cap_run),
        .i_din_evt  (events.din1),
        .i_clear    (sw_clear),
        .i_cnt      (cnt),
        .i_ovf_over (i_ovf_over[5:3]),
        .i_read_flag(i_read_flag[5:3]),
        .i_snap     (i_snap[1]),
        .o_cap      (o_cap_b),
        .o_full     (full_b)
    );

    tmr_snap_irq u_snap_irq (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cnt   (cnt),
        .i_snap  (i_snap),
        .i_full_a(full_a),
        .i_full_b(full_b),
        .o_shadow(o_shadow),
        .o_int   (o_int)
    );

endmodule

// File: design/tmr_ctrl_pkg.sv
package tmr_ctrl_pkg;

    localparam int INNER_NUM = 4; // inner inputs from the neighbour channels.

    typedef enum logic {
        MODE_CAPTURE  = 1'b0,
        MODE_WAVEFORM = 1'b1
    } tmr_mode_e;

    // code 2'b10 selects no edge at all.
    typedef enum logic [1:0] {
        EDGE_RISE = 2'b00,
        EDGE_FALL = 2'b01,
        EDGE_BOTH = 2'b11
    } tmr_edge_e;

    typedef enum logic [2:0] {
        SRC_EXT_A  = 3'd0,
        SRC_EXT_B  = 3'd1,
        SRC_INNER0 = 3'd2,
        SRC_INNER1 = 3'd3,
        SRC_INNER2 = 3'd4,
        SRC_INNER3 = 3'd5
    } tmr_src_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_COUNTING = 2'd1,
        ST_HALTED   = 2'd2
    } tmr_state_e;

    typedef struct packed {
        tmr_src_e  src;
        tmr_edge_e edge_type;
    } tmr_sel_t;

    typedef struct packed {
        logic start;
        logic stop;
        logic din0;
        logic din1;
    } tmr_events_t;

    // keep_a sits in bit 0, init_b in bit 5.
    typedef struct packed {
        logic init_b; // dout_b value loaded on restart.
        logic init_a;
        logic stop_b; // t2 hit halts instead of restarting.
        logic keep_b; // t2 hit holds dout instead of reloading init.
        logic stop_a;
        logic keep_a;
    } tmr_tgt_ctrl_t;

endpackage

// File: design/tmr_data_pkg.sv
package tmr_data_pkg;

    localparam int CNT_W   = 32;
    localparam int CAP_NUM = 3; // capture registers per bank.

    typedef logic [CNT_W-1:0] cnt_t;

    // compare targets of one output.
    typedef struct packed {
        cnt_t t2; // end of period.
        cnt_t t1; // dout goes high.
        cnt_t t0; // dout goes low.
    } tmr_targets_t;

    // one capture bank with its status bits.
    typedef struct packed {
        logic [CAP_NUM-1:0] status;
        cnt_t [CAP_NUM-1:0] val;
    } tmr_cap_t;

endpackage

// File: design/tmr_event_detect.sv
`timescale 1ns/1ps

module tmr_event_detect import tmr_ctrl_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_ext_a,
    input  logic                 i_ext_b,
    input  logic [INNER_NUM-1:0] i_inner,
    input  tmr_sel_t             i_sel_start,
    input  tmr_sel_t             i_sel_stop,
    input  tmr_sel_t             i_sel_din0,
    input  tmr_sel_t             i_sel_din1,
    input  logic                 i_sw_start,
    input  logic                 i_sw_stop,
    input  logic                 i_sw_clear,
    output tmr_events_t          o_events,
    output logic                 o_sw_clear
);

    tmr_sel_t   sel [4];    // 0 start, 1 stop, 2 din0, 3 din1.
    logic [3:0] src_now;
    logic [1:0] hist_q [4]; // [0] newest sample.
    logic [3:0] hit;
    logic [3:0] evt_q;
    logic [2:0] sw_d1_q;    // {clear, stop, start}.
    logic [2:0] sw_d2_q;

    function automatic logic pick_src(input tmr_src_e src, input logic ext_a,
                                      input logic ext_b, input logic [INNER_NUM-1:0] inner);
        case (src)
            SRC_EXT_A:  return ext_a;
            SRC_EXT_B:  return ext_b;
            SRC_INNER0: return inner[0];
            SRC_INNER1: return inner[1];
            SRC_INNER2: return inner[2];
            SRC_INNER3: return inner[3];
            default:    return 1'b0;
        endcase
    endfunction

    function automatic logic edge_hit(input tmr_edge_e kind, input logic cur, input logic prev);
        case (kind)
            EDGE_RISE: return cur & ~prev;
            EDGE_FALL: return ~cur & prev;
            EDGE_BOTH: return cur ^ prev;
            default:   return 1'b0;
        endcase
    endfunction

    assign sel[0] = i_sel_start;
    assign sel[1] = i_sel_stop;
    assign sel[2] = i_sel_din0;
    assign sel[3] = i_sel_din1;

    // each selector looks at its own edge field.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_now[i] = pick_src(sel[i].src, i_ext_a, i_ext_b, i_inner);
            hit[i]     = edge_hit(sel[i].edge_type, hist_q[i][0], hist_q[i][1]);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 4; i++) begin
                hist_q[i] <= 2'b00;
            end
            evt_q   <= '0;
            sw_d1_q <= '0;
            sw_d2_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                hist_q[i] <= {hist_q[i][0], src_now[i]};
            end
            evt_q   <= hit;
            sw_d1_q <= {i_sw_clear, i_sw_stop, i_sw_start};
            sw_d2_q <= sw_d1_q; // same latency as the pin path.
        end
    end

    always_comb begin
        o_events.start = evt_q[0] | sw_d2_q[0];
        o_events.stop  = evt_q[1] | sw_d2_q[1];
        o_events.din0  = evt_q[2];
        o_events.din1  = evt_q[3];
    end

    assign o_sw_clear = sw_d2_q[2];

endmodule

// File: design/tmr_mode_ctrl.sv
`timescale 1ns/1ps

module tmr_mode_ctrl import tmr_ctrl_pkg::*, tmr_data_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_enable,
    input  tmr_mode_e     i_mode,
    input  tmr_tgt_ctrl_t i_tgt_ctrl,
    input  tmr_events_t   i_events,
    input  logic          i_sw_clear,
    input  logic          i_hit_t2_a,
    input  logic          i_hit_t2_b,
    output cnt_t          o_cnt,
    output logic          o_wave_run,
    output logic          o_cap_run,
    output logic          o_oen_a,
    output logic          o_oen_b,
    output logic          o_restart
);

    tmr_state_e state_q;
    tmr_mode_e  mode_q;  // mode taken at the last start.
    cnt_t       cnt_q;
    logic       oen_q;
    logic       t2_stop;
    logic       t2_restart;
    logic       running;

    assign running    = (state_q == ST_COUNTING);
    assign o_wave_run = running && (mode_q == MODE_WAVEFORM);
    assign o_cap_run  = running && (mode_q == MODE_CAPTURE);

    // t2 handling only applies while a waveform is running.
    assign t2_stop = o_wave_run &&
                     ((i_hit_t2_a && i_tgt_ctrl.stop_a) || (i_hit_t2_b && i_tgt_ctrl.stop_b));
    assign t2_restart = o_wave_run &&
                        ((i_hit_t2_a && !i_tgt_ctrl.stop_a) || (i_hit_t2_b && !i_tgt_ctrl.stop_b));

    // outputs reload their init values on every waveform start.
    assign o_restart = i_enable && i_events.start && (i_mode == MODE_WAVEFORM);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            mode_q  <= MODE_CAPTURE;
        end else if (!i_enable) begin
            state_q <= ST_IDLE;
            mode_q  <= MODE_CAPTURE;
        end else begin
            case (state_q)
                ST_IDLE, ST_HALTED: begin
                    if (i_events.start) begin
                        state_q <= ST_COUNTING;
                        mode_q  <= i_mode;
                    end
                end
                ST_COUNTING: begin
                    if (i_events.stop || t2_stop) begin // stop wins over start.
                        state_q <= ST_HALTED;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!i_enable || i_sw_clear) begin
            cnt_q <= '0;
        end else if (t2_restart) begin
            cnt_q <= '0;
        end else if (running) begin
            cnt_q <= cnt_q + CNT_W'(1); // wraps from all ones.
        end
    end

    // both enables move together, high means the pins are inputs.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            oen_q <= 1'b1;
        end else if (!i_enable) begin
            oen_q <= 1'b1;
        end else if (i_events.stop || t2_stop) begin
            oen_q <= 1'b1;
        end else if (i_events.start) begin
            oen_q <= (i_mode != MODE_WAVEFORM);
        end
    end

    assign o_cnt   = cnt_q;
    assign o_oen_a = oen_q;
    assign o_oen_b = oen_q;

endmodule

// File: design/tmr_snap_irq.sv
`timescale 1ns/1ps

module tmr_snap_irq import tmr_data_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  cnt_t       i_cnt,
    input  logic [1:0] i_snap, // bit 1 is taken by the capture banks.
    input  logic       i_full_a,
    input  logic       i_full_b,
    output cnt_t       o_shadow,
    output logic [2:0] o_int
);

    logic snap_d_q;
    logic full_a_d_q;
    logic full_b_d_q;
    logic all_ones_d_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            snap_d_q     <= 1'b0;
            full_a_d_q   <= 1'b0;
            full_b_d_q   <= 1'b0;
            all_ones_d_q <= 1'b0;
            o_shadow     <= '0;
            o_int        <= '0;
        end else begin
            snap_d_q     <= i_snap[0];
            full_a_d_q   <= i_full_a;
            full_b_d_q   <= i_full_b;
            all_ones_d_q <= &i_cnt;
            if (i_snap[0] && !snap_d_q) begin
                o_shadow <= i_cnt;
            end
            o_int[0] <= i_full_a && !full_a_d_q; // bank a just filled.
            o_int[1] <= i_full_b && !full_b_d_q;
            o_int[2] <= all_ones_d_q && (i_cnt == '0); // counter wrap.
        end
    end

endmodule

// File: design/tmr_waveform_gen.sv
`timescale 1ns/1ps

module tmr_waveform_gen import tmr_ctrl_pkg::*, tmr_data_pkg::*; (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_enable,
    input  logic          i_wave_run,
    input  logic          i_restart,
    input  cnt_t          i_cnt,
    input  tmr_targets_t  i_tgt_a,
    input  tmr_targets_t  i_tgt_b,
    input  tmr_tgt_ctrl_t i_tgt_ctrl,
    output logic          o_dout_a,
    output logic          o_dout_b,
    output logic          o_hit_t2_a,
    output logic          o_hit_t2_b
);

    // t0 clears, t1 sets, t2 holds or reloads init.
    function automatic logic next_dout(input logic cur, input cnt_t cnt,
                                       input tmr_targets_t tgt, input logic keep,
                                       input logic init);
        logic nxt;
        nxt = cur;
        if (cnt == tgt.t0) begin
            nxt = 1'b0;
        end else if (cnt == tgt.t1) begin
            nxt = 1'b1;
        end else if (cnt == tgt.t2) begin
            nxt = keep ? cur : init;
        end
        return nxt;
    endfunction

    assign o_hit_t2_a = i_wave_run && (i_cnt == i_tgt_a.t2);
    assign o_hit_t2_b = i_wave_run && (i_cnt == i_tgt_b.t2);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dout_a <= 1'b0;
            o_dout_b <= 1'b0;
        end else if (!i_enable) begin
            o_dout_a <= 1'b0;
            o_dout_b <= 1'b0;
        end else if (i_restart) begin
            o_dout_a <= i_tgt_ctrl.init_a;
            o_dout_b <= i_tgt_ctrl.init_b;
        end else if (i_wave_run) begin
            o_dout_a <= next_dout(o_dout_a, i_cnt, i_tgt_a, i_tgt_ctrl.keep_a, i_tgt_ctrl.init_a);
            o_dout_b <= next_dout(o_dout_b, i_cnt, i_tgt_b, i_tgt_ctrl.keep_b, i_tgt_ctrl.init_b);
        end
    end

endmodule

// File: filelist.f
design/tmr_ctrl_pkg.sv
design/tmr_data_pkg.sv
design/tmr_event_detect.sv
design/tmr_mode_ctrl.sv
design/tmr_waveform_gen.sv
design/tmr_capture_bank.sv
design/tmr_snap_irq.sv
design/tmr_channel_top.sv
testbench/tb_tmr_channel.sv

// File: testbench/tb_tmr_channel.sv
`timescale 1ns/1ps

module tb_tmr_channel import tmr_ctrl_pkg::*, tmr_data_pkg::*; ();

    logic                 i_clk;
    logic                 i_rst_n;
    logic                 i_enable;
    tmr_mode_e            i_mode;
    logic                 i_ext_a;
    logic                 i_ext_b;
    logic [INNER_NUM-1:0] i_inner;
    tmr_sel_t             i_sel_start;
    tmr_sel_t             i_sel_stop;
    tmr_sel_t             i_sel_din0;
    tmr_sel_t             i_sel_din1;
    logic                 i_sw_start;
    logic                 i_sw_stop;
    logic                 i_sw_clear;
    tmr_tgt_ctrl_t        i_tgt_ctrl;
    tmr_targets_t         i_tgt_a;
    tmr_targets_t         i_tgt_b;
    logic [5:0]           i_ovf_over;
    logic [5:0]           i_read_flag;
    logic [1:0]           i_snap;
    tmr_cap_t             o_cap_a;
    tmr_cap_t             o_cap_b;
    cnt_t                 o_shadow;
    logic [2:0]           o_int;
    logic                 o_dout_a;
    logic                 o_dout_b;
    logic                 o_oen_a;
    logic                 o_oen_b;

    integer           fd;
    integer           r;
    integer           seed = 32'h51dd4956;
    int               errors = 0;
    int               cycles = 0;
    int               limit = 100; // reset and slack, each scenario adds its length.
    int               int_seen [3] = '{0, 0, 0};
    int               args [6];
    logic [8*16-1:0]  op;
    logic [8*128-1:0] line;
    logic             done;

    tmr_channel_top uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles > limit);
        $display("Timeout: the scenarios did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

    // o_int bits are one-cycle pulses.
    always @(negedge i_clk) begin
        for (int i = 0; i < 3; i++) begin
            if (o_int[i]) begin
                int_seen[i] = int_seen[i] + 1;
            end
        end
    end

    function automatic tmr_sel_t make_sel(input tmr_src_e src, input tmr_edge_e kind);
        tmr_sel_t s;
        s.src       = src;
        s.edge_type = kind;
        return s;
    endfunction

    task automatic step(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic read_args(input int n);
        for (int i = 0; i < n; i++) begin
            r = $fscanf(fd, "%d", args[i]);
            if (r != 1) begin
                errors++;
                $display("A test data line is missing an argument");
            end
        end
    endtask

    task automatic pulse_start();
        i_ext_a = 1'b1;
        step(1);
        i_ext_a = 1'b0;
    endtask

    task automatic pulse_stop();
        i_ext_b = 1'b1;
        step(1);
        i_ext_b = 1'b0;
    endtask

    // bit 0 drives din0, bit 1 drives din1.
    task automatic pulse_din(input logic [1:0] which);
        i_inner[1:0] = which;
        step(1);
        i_inner[1:0] = 2'b00;
    endtask

    task automatic clear_counter();
        i_sw_clear = 1'b1;
        step(1);
        i_sw_clear = 1'b0;
        step(4); // two delay stages, then the clear edge.
    endtask

    task automatic take_snapshot(input logic [1:0] bits);
        i_snap = bits;
        step(1);
        i_snap = 2'b00;
        step(1);
    endtask

    task automatic wait_oen(input logic level);
        while (o_oen_a !== level) begin
            step(1);
        end
    endtask

    task automatic run_count(input int n, input int exp_shadow);
        i_mode     = MODE_CAPTURE;
        i_sel_stop = make_sel(SRC_EXT_A, EDGE_RISE); // start and stop on the same pin.
        clear_counter();
        pulse_start();
        step(n - 1);
        pulse_start();
        step(4);
        take_snapshot(2'b01);
        check_value(o_shadow, exp_shadow, "shadow after start and stop");
    endtask

    task automatic wave_run(input int tgt0, input int tgt1, input int tgt2, input int periods,
                            input int exp_high, input int exp_period);
        int   high = 0;
        int   oen_bad = 0;
        int   last_rise = -1;
        logic prev = 1'b0;
        i_mode      = MODE_WAVEFORM;
        i_sel_stop  = make_sel(SRC_EXT_B, EDGE_RISE);
        i_tgt_ctrl  = '0;
        i_tgt_a.t0  = tgt0;
        i_tgt_a.t1  = tgt1;
        i_tgt_a.t2  = tgt2;
        i_tgt_b     = i_tgt_a;
        clear_counter();
        pulse_start();
        wait_oen(1'b0);
        for (int i = 0; i < periods * (tgt2 + 1); i++) begin
            high    += o_dout_a;
            oen_bad += o_oen_a;
            if (o_dout_a && !prev) begin
                if (last_rise >= 0) begin
                    check_value(i - last_rise, exp_period, "dout_a period");
                end
                last_rise = i;
            end
            prev = o_dout_a;
            step(1);
        end
        check_value(high, exp_high, "dout_a high cycles");
        check_value(oen_bad, 0, "o_oen_a high while running");
        pulse_stop();
        wait_oen(1'b1);
    endtask

    task automatic capture_run(input int pulses, input int exp_status, input int exp_int);
        int gap [CAP_NUM];
        i_mode     = MODE_CAPTURE;
        i_sel_stop = make_sel(SRC_EXT_B, EDGE_RISE);
        clear_counter();
        int_seen[0] = 0;
        int_seen[1] = 0;
        pulse_start();
        step(4);
        for (int i = 0; i < pulses; i++) begin
            gap[i] = 2 + ({$random(seed)} % 8);
            if (i > 0) begin
                step(gap[i] - 1); // the pulse itself is one cycle.
            end
            pulse_din(2'b11);
        end
        step(4);
        take_snapshot(2'b10);
        for (int i = 1; i < pulses; i++) begin
            check_value(o_cap_a.val[i] - o_cap_a.val[i-1], gap[i], "capture spacing");
            check_value(o_cap_b.val[i] - o_cap_b.val[i-1], gap[i], "bank b capture spacing");
        end
        check_value(o_cap_a.status, exp_status, "bank a status");
        check_value(o_cap_b.status, exp_status, "bank b status");
        check_value(int_seen[0], exp_int, "o_int[0] pulses");
        check_value(int_seen[1], exp_int, "o_int[1] pulses");
    endtask

    task automatic overflow_run(input int over, input int read, input int exp_changed,
                                input int exp_status);
        cnt_t a0_before;
        take_snapshot(2'b10);
        a0_before  = o_cap_a.val[0];
        i_ovf_over = {5'b00000, over[0]};
        pulse_din(2'b01);
        step(4);
        take_snapshot(2'b10);
        check_value(o_cap_a.val[0] != a0_before, exp_changed, "a0 after an extra din0 edge");
        // rotation back to a0.
        repeat (2) begin
            step(2);
            pulse_din(2'b01);
        end
        if (read != 0) begin
            i_read_flag[0] = 1'b1;
            step(1);
            i_read_flag[0] = 1'b0;
        end
        step(4);
        take_snapshot(2'b10);
        check_value(o_cap_a.status, exp_status, "bank a status after read flag");
        i_ovf_over = '0;
    endtask

    task automatic clear_run(input int exp_shadow, input int exp_status);
        i_sel_stop = make_sel(SRC_EXT_B, EDGE_RISE);
        pulse_stop();
        step(4);
        clear_counter();
        take_snapshot(2'b11);
        check_value(o_shadow, exp_shadow, "shadow after clear");
        for (int i = 0; i < CAP_NUM; i++) begin
            check_value(o_cap_a.val[i], 0, "capture a after clear");
            check_value(o_cap_b.val[i], 0, "capture b after clear");
        end
        check_value(o_cap_a.status, exp_status, "bank a status after clear");
        check_value(o_cap_b.status, exp_status, "bank b status after clear");
    endtask

    task automatic disable_run(input int exp_oen, input int exp_dout);
        i_mode            = MODE_WAVEFORM;
        i_tgt_ctrl        = '0;
        i_tgt_ctrl.init_a = 1'b1;
        i_tgt_ctrl.init_b = 1'b1;
        pulse_start();
        wait_oen(1'b0);
        check_value(o_dout_a, 1, "dout_a after restart with init set");
        i_enable = 1'b0;
        step(2);
        check_value(o_oen_a, exp_oen, "o_oen_a while disabled");
        check_value(o_oen_b, exp_oen, "o_oen_b while disabled");
        check_value(o_dout_a, exp_dout, "o_dout_a while disabled");
        check_value(o_dout_b, exp_dout, "o_dout_b while disabled");
        i_enable   = 1'b1;
        i_tgt_ctrl = '0;
        step(2);
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_enable    = 1'b1;
        i_mode      = MODE_CAPTURE;
        i_ext_a     = 1'b0;
        i_ext_b     = 1'b0;
        i_inner     = '0;
        i_sel_start = make_sel(SRC_EXT_A, EDGE_RISE);
        i_sel_stop  = make_sel(SRC_EXT_B, EDGE_RISE);
        i_sel_din0  = make_sel(SRC_INNER0, EDGE_RISE);
        i_sel_din1  = make_sel(SRC_INNER1, EDGE_RISE);
        i_sw_start  = 1'b0;
        i_sw_stop   = 1'b0;
        i_sw_clear  = 1'b0;
        i_tgt_ctrl  = '0;
        i_tgt_a     = '0;
        i_tgt_b     = '0;
        i_ovf_over  = '0;
        i_read_flag = '0;
        i_snap      = '0;
        done        = 1'b0;
        step(5);
        i_rst_n = 1'b1;
        step(2);
        fd = $fopen("testbench/tmr_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file testbench/tmr_testdata.txt");
            $display("Checks failed");
            $finish;
        end else begin
            while (!done) begin
                r = $fscanf(fd, "%s", op);
                if (r != 1) begin
                    done = 1'b1;
                end else if (op == "#") begin
                    r = $fgets(line, fd);
                end else if (op == "run") begin
                    read_args(2);
                    limit += args[0] + 30;
                    run_count(args[0], args[1]);
                end else if (op == "wave") begin
                    read_args(6);
                    limit += args[3] * (args[2] + 1) + 40;
                    wave_run(args[0], args[1], args[2], args[3], args[4], args[5]);
                end else if (op == "capture") begin
                    read_args(3);
                    limit += args[0] * 12 + 30;
                    capture_run(args[0], args[1], args[2]);
                end else if (op == "overflow") begin
                    read_args(4);
                    limit += 60;
                    overflow_run(args[0], args[1], args[2], args[3]);
                end else if (op == "clear") begin
                    read_args(2);
                    limit += 40;
                    clear_run(args[0], args[1]);
                end else if (op == "disable") begin
                    read_args(2);
                    limit += 30;
                    disable_run(args[0], args[1]);
                end else begin
                    errors++;
                    $display("Unknown opcode %0s in the test data file", op);
                    r = $fgets(line, fd);
                end
            end
            $fclose(fd);
            // the counter never comes near all ones in these scenarios.
            check_value(int_seen[2], 0, "o_int[2] pulses without a counter wrap");
            $display("Run finished with %0d errors", errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

// File: testbench/tmr_testdata.txt
# columns: opcode, then its arguments, then the expected values
# run n shadow / wave t0 t1 t2 periods high period / capture pulses status int0
# overflow over read changed status / clear shadow status / disable oen dout
run 17 17
run 5 5
wave 9 3 14 3 18 15
wave 20 4 31 2 32 32
capture 3 7 1
overflow 0 0 0 7
overflow 1 1 1 6
clear 0 0
disable 1 0
